// File: fma_pkg.sv
// shared widths, fp16 field constants, bus address map and typedefs for the fma row
package fma_pkg;

    // row size
    localparam int LANES = 4;

    // fp16 format
    localparam int FP_W     = 16;
    localparam int EXP_W    = 5;
    localparam int MAN_W    = 10;
    localparam int EXP_BIAS = 15;
    localparam int EMIN     = -14;   // smallest normal exponent
    localparam int SIG_W    = MAN_W + 1;

    // multiplier and adder widths
    localparam int BOOTH_DIGITS = (SIG_W + 2) / 2;   // radix-4 digits incl. top zero pad
    localparam int PP_W         = 24;
    localparam int ACC_W        = 64;   // aligned add window, exact over the operand range

    // wishbone address map, one fp16 word per address
    localparam int ADR_W  = 4;
    localparam int ADR_A  = 0;
    localparam int ADR_B0 = 1;
    localparam int ADR_C0 = 5;
    localparam int ADR_R0 = 9;

    // raw fp16 word
    typedef logic [FP_W-1:0] fp16_t;

    // significand with hidden bit
    typedef logic [SIG_W-1:0] sig_t;

    // unbiased exponent, wide enough for product and alignment math
    typedef logic signed [6:0] exp_t;

    // one booth partial product row, two's complement
    typedef logic [PP_W-1:0] pp_t;

    // aligned sum window
    typedef logic [ACC_W-1:0] acc_t;

    // leading zero count, holds ACC_W for an all-zero window
    typedef logic [$clog2(ACC_W):0] lzc_t;

    typedef logic [ADR_W-1:0] wb_adr_t;

endpackage

// File: fma_normalize.sv
// leading zero count, normalize, round to nearest even, flush tiny results and pack the fp16 word at the end of each lane
`timescale 1ns/1ps

module fma_normalize (
    input  fma_pkg::acc_t   sum_mag,
    input  logic            sum_sign,
    input  fma_pkg::exp_t   sum_exp,    // weight of sum_mag bit 0
    output fma_pkg::fp16_t  fp16
);

    fma_pkg::lzc_t           lzc;
    fma_pkg::acc_t           norm;
    fma_pkg::sig_t           mant;
    logic                    guard, rnd, sticky, round_up;
    logic [fma_pkg::SIG_W:0] mant_rnd;
    logic                    rnd_carry;
    logic [fma_pkg::MAN_W-1:0] frac;
    logic signed [8:0]       res_exp;
    logic [8:0]              biased;

    // priority encoder where the highest set bit wins
    always_comb begin
        lzc = fma_pkg::lzc_t'(fma_pkg::ACC_W);
        for (int i = 0; i < fma_pkg::ACC_W; i++) begin
            if (sum_mag[i])
                lzc = fma_pkg::lzc_t'(fma_pkg::ACC_W - 1 - i);
        end
    end

    assign norm = sum_mag << lzc;   // leading one now at the msb

    assign mant   = norm[fma_pkg::ACC_W-1 -: fma_pkg::SIG_W];
    assign guard  = norm[fma_pkg::ACC_W-1-fma_pkg::SIG_W];
    assign rnd    = norm[fma_pkg::ACC_W-2-fma_pkg::SIG_W];
    assign sticky = |norm[fma_pkg::ACC_W-3-fma_pkg::SIG_W:0];

    // ties go to the even neighbour
    assign round_up  = guard & (rnd | sticky | mant[0]);
    assign mant_rnd  = {1'b0, mant} + (fma_pkg::SIG_W+1)'(round_up);
    assign rnd_carry = mant_rnd[fma_pkg::SIG_W];
    // on carry the significand is 10.000..0 and its low fraction bits are zero
    assign frac      = mant_rnd[fma_pkg::MAN_W-1:0];

    // exponent of the leading one plus one if rounding carried out
    assign res_exp = 9'(sum_exp) + 9'(fma_pkg::ACC_W - 1) - 9'(lzc) + 9'(rnd_carry);
    assign biased  = res_exp + 9'(fma_pkg::EXP_BIAS);

    always_comb begin
        if (sum_mag == '0) begin
            fp16 = '0;                                  // exact cancellation gives +0
        end else if (res_exp < fma_pkg::EMIN) begin
            fp16 = {sum_sign, {(fma_pkg::FP_W-1){1'b0}}};   // flush to a signed zero
        end else begin
            fp16 = {sum_sign, biased[fma_pkg::EXP_W-1:0], frac};
        end
    end

endmodule

// File: fma_lane.sv
// one fma lane: booth select on b, csa tree, align c, signed add, then hand off to the normalizer
`timescale 1ns/1ps

module fma_lane (
    input  logic            sign_a,
    input  fma_pkg::exp_t   exp_a,
    input  fma_pkg::pp_t    mul_one,
    input  fma_pkg::pp_t    mul_two,
    input  fma_pkg::pp_t    mul_minus_one,
    input  fma_pkg::pp_t    mul_minus_two,
    input  fma_pkg::fp16_t  b,
    input  fma_pkg::fp16_t  c,
    output fma_pkg::fp16_t  lane_result
);

    logic                       sign_b, sign_c, sign_p;
    fma_pkg::exp_t              exp_b, exp_c;
    fma_pkg::sig_t              sig_b, sig_c;
    logic [fma_pkg::SIG_W+1:0]  booth_src;
    fma_pkg::pp_t               pp [fma_pkg::BOOTH_DIGITS];
    logic [2*fma_pkg::PP_W-1:0] l1a, l1b, l2, l3;
    fma_pkg::pp_t               prod;
    fma_pkg::exp_t              prod_lsb, c_lsb, ref_exp, align_diff;
    fma_pkg::acc_t              prod_win, c_win, sum;
    logic                       sum_sign;
    fma_pkg::acc_t              sum_mag;

    // 3:2 compressor layer, carry word returned in the upper half
    function automatic logic [2*fma_pkg::PP_W-1:0] csa(input fma_pkg::pp_t x,
                                                       input fma_pkg::pp_t y,
                                                       input fma_pkg::pp_t z);
        fma_pkg::pp_t s;
        fma_pkg::pp_t cy;
        s  = x ^ y ^ z;
        cy = ((x & y) | (y & z) | (x & z)) << 1;
        return {cy, s};
    endfunction

    assign sign_b = b[fma_pkg::FP_W-1];
    assign sign_c = c[fma_pkg::FP_W-1];
    assign exp_b  = fma_pkg::exp_t'(b[fma_pkg::MAN_W +: fma_pkg::EXP_W])
                  - fma_pkg::exp_t'(fma_pkg::EXP_BIAS);
    assign exp_c  = fma_pkg::exp_t'(c[fma_pkg::MAN_W +: fma_pkg::EXP_W])
                  - fma_pkg::exp_t'(fma_pkg::EXP_BIAS);
    assign sig_b  = {1'b1, b[fma_pkg::MAN_W-1:0]};
    assign sig_c  = {1'b1, c[fma_pkg::MAN_W-1:0]};
    assign sign_p = sign_a ^ sign_b;

    // zero below lsb and above msb so b reads as unsigned
    assign booth_src = {1'b0, sig_b, 1'b0};

    always_comb begin
        for (int i = 0; i < fma_pkg::BOOTH_DIGITS; i++) begin
            case (booth_src[2*i +: 3])
                3'b001, 3'b010: pp[i] = mul_one << (2*i);
                3'b011:         pp[i] = mul_two << (2*i);
                3'b100:         pp[i] = mul_minus_two << (2*i);
                3'b101, 3'b110: pp[i] = mul_minus_one << (2*i);
                default:        pp[i] = '0;   // 000 and 111
            endcase
        end
    end

    // 6 rows -> 2 via three csa levels
    assign l1a  = csa(pp[0], pp[1], pp[2]);
    assign l1b  = csa(pp[3], pp[4], pp[5]);
    assign l2   = csa(l1a[fma_pkg::PP_W-1:0], l1a[2*fma_pkg::PP_W-1:fma_pkg::PP_W],
                      l1b[fma_pkg::PP_W-1:0]);
    assign l3   = csa(l2[fma_pkg::PP_W-1:0], l2[2*fma_pkg::PP_W-1:fma_pkg::PP_W],
                      l1b[2*fma_pkg::PP_W-1:fma_pkg::PP_W]);
    assign prod = l3[fma_pkg::PP_W-1:0] + l3[2*fma_pkg::PP_W-1:fma_pkg::PP_W];  // 22 bit magnitude

    // weight of the lsb of each addend
    assign prod_lsb = exp_a + exp_b - fma_pkg::exp_t'(2*fma_pkg::MAN_W);
    assign c_lsb    = exp_c - fma_pkg::exp_t'(fma_pkg::MAN_W);

    // lower lsb sits at bit 0, the other one moves up
    always_comb begin
        if (prod_lsb <= c_lsb) begin
            ref_exp    = prod_lsb;
            align_diff = c_lsb - prod_lsb;
            prod_win   = fma_pkg::acc_t'(prod);
            c_win      = fma_pkg::acc_t'(sig_c) << align_diff;
        end else begin
            ref_exp    = c_lsb;
            align_diff = prod_lsb - c_lsb;
            prod_win   = fma_pkg::acc_t'(prod) << align_diff;
            c_win      = fma_pkg::acc_t'(sig_c);
        end
    end

    assign sum      = (sign_p ? -prod_win : prod_win) + (sign_c ? -c_win : c_win);
    assign sum_sign = sum[fma_pkg::ACC_W-1];
    assign sum_mag  = sum_sign ? -sum : sum;

    fma_normalize u_norm (
        .sum_mag  (sum_mag),
        .sum_sign (sum_sign),
        .sum_exp  (ref_exp),
        .fp16     (lane_result)
    );

endmodule

// File: fma_row.sv
// row of fma lanes sharing operand a, unpacks a once and builds its booth multiples for all lanes
`timescale 1ns/1ps

module fma_row (
    input  fma_pkg::fp16_t                         op_a,
    input  fma_pkg::fp16_t [fma_pkg::LANES-1:0]    op_b,
    input  fma_pkg::fp16_t [fma_pkg::LANES-1:0]    op_c,
    output fma_pkg::fp16_t [fma_pkg::LANES-1:0]    lane_result
);

    logic            sign_a;
    fma_pkg::exp_t   exp_a;
    fma_pkg::sig_t   sig_a;

    fma_pkg::pp_t    mul_one;
    fma_pkg::pp_t    mul_two;
    fma_pkg::pp_t    mul_minus_one;
    fma_pkg::pp_t    mul_minus_two;

    // normal inputs only, hidden bit always set
    assign sign_a = op_a[fma_pkg::FP_W-1];
    assign exp_a  = fma_pkg::exp_t'(op_a[fma_pkg::MAN_W +: fma_pkg::EXP_W])
                  - fma_pkg::exp_t'(fma_pkg::EXP_BIAS);
    assign sig_a  = {1'b1, op_a[fma_pkg::MAN_W-1:0]};

    // booth multiples, computed once per row
    assign mul_one       = fma_pkg::pp_t'(sig_a);
    assign mul_two       = mul_one << 1;
    assign mul_minus_one = -mul_one;   // two's complement, no separate correction bit
    assign mul_minus_two = -mul_two;

    for (genvar g = 0; g < fma_pkg::LANES; g++) begin : g_lane
        fma_lane u_lane (
            .sign_a        (sign_a),
            .exp_a         (exp_a),
            .mul_one       (mul_one),
            .mul_two       (mul_two),
            .mul_minus_one (mul_minus_one),
            .mul_minus_two (mul_minus_two),
            .b             (op_b[g]),
            .c             (op_c[g]),
            .lane_result   (lane_result[g])
        );
    end

endmodule

// File: fma_wb_regs.sv
// wishbone classic slave holding the a/b/c operand registers and the read mux over operands and results
`timescale 1ns/1ps

module fma_wb_regs (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  fma_pkg::wb_adr_t                       wb_adr,
    input  fma_pkg::fp16_t                         wb_dat_w,
    input  fma_pkg::fp16_t [fma_pkg::LANES-1:0]    result,
    output fma_pkg::fp16_t                         wb_dat_r,
    output logic                                   wb_ack,
    output fma_pkg::fp16_t                         op_a,
    output fma_pkg::fp16_t [fma_pkg::LANES-1:0]    op_b,
    output fma_pkg::fp16_t [fma_pkg::LANES-1:0]    op_c
);

    logic req;      // new request, not yet acked
    logic wr_en;

    assign req   = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en = req & wb_we;

    // ack one clock after the request, single cycle wide
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // operand writes land on the ack edge
    always_ff @(posedge clk) begin
        if (reset) begin
            op_a <= '0;
            op_b <= '0;
            op_c <= '0;
        end else if (wr_en) begin
            if (wb_adr == fma_pkg::wb_adr_t'(fma_pkg::ADR_A))
                op_a <= wb_dat_w;
            for (int i = 0; i < fma_pkg::LANES; i++) begin
                if (wb_adr == fma_pkg::wb_adr_t'(fma_pkg::ADR_B0 + i))
                    op_b[i] <= wb_dat_w;
                if (wb_adr == fma_pkg::wb_adr_t'(fma_pkg::ADR_C0 + i))
                    op_c[i] <= wb_dat_w;
            end
            // result and unmapped addresses take no write
        end
    end

    // read mux, held address is still valid during the ack cycle
    always_comb begin
        wb_dat_r = '0;  // unmapped reads return zero
        if (wb_adr == fma_pkg::wb_adr_t'(fma_pkg::ADR_A))
            wb_dat_r = op_a;
        for (int i = 0; i < fma_pkg::LANES; i++) begin
            if (wb_adr == fma_pkg::wb_adr_t'(fma_pkg::ADR_B0 + i))
                wb_dat_r = op_b[i];
            if (wb_adr == fma_pkg::wb_adr_t'(fma_pkg::ADR_C0 + i))
                wb_dat_r = op_c[i];
            if (wb_adr == fma_pkg::wb_adr_t'(fma_pkg::ADR_R0 + i))
                wb_dat_r = result[i];
        end
    end

endmodule

// File: fma_result_regs.sv
// result register bank, captures every lane result each clock ahead of the bus read mux
`timescale 1ns/1ps

module fma_result_regs (
    input  logic                                   clk,
    input  logic                                   reset,
    input  fma_pkg::fp16_t [fma_pkg::LANES-1:0]    lane_result,
    output fma_pkg::fp16_t [fma_pkg::LANES-1:0]    result
);

    // breaks the long path from the lane datapath to wb_dat_r
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= lane_result;  // free running, no enable
        end
    end

endmodule

// File: fma_row_top.sv
// top level of the fma row, wishbone register side, lane row and result registers
`timescale 1ns/1ps

module fma_row_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  fma_pkg::wb_adr_t  wb_adr,
    input  fma_pkg::fp16_t    wb_dat_w,
    output fma_pkg::fp16_t    wb_dat_r,
    output logic              wb_ack
);

    fma_pkg::fp16_t                        op_a;
    fma_pkg::fp16_t [fma_pkg::LANES-1:0]   op_b;
    fma_pkg::fp16_t [fma_pkg::LANES-1:0]   op_c;
    fma_pkg::fp16_t [fma_pkg::LANES-1:0]   lane_result;
    fma_pkg::fp16_t [fma_pkg::LANES-1:0]   result;

    fma_wb_regs u_wb_regs (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .result   (result),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .op_a     (op_a),
        .op_b     (op_b),
        .op_c     (op_c)
    );

    // combinational lanes
    fma_row u_row (
        .op_a        (op_a),
        .op_b        (op_b),
        .op_c        (op_c),
        .lane_result (lane_result)
    );

    fma_result_regs u_result_regs (
        .clk         (clk),
        .reset       (reset),
        .lane_result (lane_result),
        .result      (result)
    );

endmodule

// File: fma_props.sv
// wishbone protocol assertions, bound into the fma row top level
`timescale 1ns/1ps

module fma_props (
    input logic           clk,
    input logic           reset,
    input logic           wb_cyc,
    input logic           wb_stb,
    input logic           wb_we,
    input fma_pkg::fp16_t wb_dat_r,
    input logic           wb_ack
);

    // ack answers a request seen on the previous edge
    a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a request in the previous cycle");

    a_ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    a_read_known: assert property (@(posedge clk) disable iff (reset)
        (wb_ack && !wb_we) |-> !$isunknown(wb_dat_r))
        else $error("wb_dat_r unknown during a read ack");

endmodule

bind fma_row_top fma_props u_props (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
);

// File: tb_fma_model.svh
// fma reference model with an exact integer sum and nearest-even rounding, plus typed compare tasks
`ifndef TB_FMA_MODEL_SVH
`define TB_FMA_MODEL_SVH

function automatic fma_pkg::fp16_t fma_model(input fma_pkg::fp16_t a, input fma_pkg::fp16_t b,
                                             input fma_pkg::fp16_t c);
    logic signed [95:0] prod;
    logic signed [95:0] addend;
    logic signed [95:0] total;
    logic [95:0]        mag;
    logic [95:0]        keep;
    logic [95:0]        rem;
    logic [95:0]        half;
    logic               sign;
    int                 ea, eb, ec, base, p, e, sh, i;
    ea     = int'(a[14:10]) - fma_pkg::EXP_BIAS;
    eb     = int'(b[14:10]) - fma_pkg::EXP_BIAS;
    ec     = int'(c[14:10]) - fma_pkg::EXP_BIAS;
    prod   = 96'({1'b1, a[9:0]}) * 96'({1'b1, b[9:0]});
    addend = 96'({1'b1, c[9:0]});
    base   = (ea + eb - 20 < ec - 10) ? ea + eb - 20 : ec - 10;  // weight of bit 0
    prod   = prod << (ea + eb - 20 - base);
    addend = addend << (ec - 10 - base);
    if (a[15] ^ b[15])
        prod = -prod;
    if (c[15])
        addend = -addend;
    total = prod + addend;
    if (total == '0)
        return '0;
    sign = total[95];
    mag  = sign ? -total : total;
    p    = 0;
    for (i = 0; i < 96; i++)
        if (mag[i])
            p = i;
    e = base + p;  // exponent of the leading one
    if (p > 10) begin
        sh   = p - 10;
        keep = mag >> sh;
        rem  = mag - (keep << sh);
        half = 96'd1 << (sh - 1);
        if (rem > half || (rem == half && keep[0]))
            keep = keep + 96'd1;
        if (keep[11]) begin
            keep = keep >> 1;  // rounded up to the next power of two
            e    = e + 1;
        end
    end else begin
        keep = mag << (10 - p);
    end
    if (e < fma_pkg::EMIN)
        return {sign, 15'b0};
    return {sign, 5'(e + fma_pkg::EXP_BIAS), keep[9:0]};
endfunction

task automatic check_fp16(input string what, input int lane, input fma_pkg::fp16_t got,
                          input fma_pkg::fp16_t expected);
    if (got !== expected) begin
        $display("Fail at %0d ns: %s, lane %0d, got %h, expected %h",
                 $time, what, lane, got, expected);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic check_ack(input string what, input logic got, input logic expected);
    if (got !== expected) begin
        $display("Fail at %0d ns: %s, wb_ack is %b, expected %b", $time, what, got, expected);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

`endif

// File: tb_fma_row.sv
// testbench for the fma row, drives wishbone transfers and checks every lane against the model
`timescale 1ns/1ps

module tb_fma_row;

    logic             clk;
    logic             reset;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    fma_pkg::wb_adr_t wb_adr;
    fma_pkg::fp16_t   wb_dat_w;
    fma_pkg::fp16_t   wb_dat_r;
    logic             wb_ack;

    fma_pkg::fp16_t   cur_a;                        // mirror of the operand registers
    fma_pkg::fp16_t   cur_b [fma_pkg::LANES];
    fma_pkg::fp16_t   cur_c [fma_pkg::LANES];
    fma_pkg::fp16_t   rd;
    logic [15:0]      lfsr = 16'd12;
    int               pass_count = 0;
    int               fail_count = 0;
    int               test_start = 0;
    int               cycle_count = 0;
    int               rounds = 200;
    int               xfer_limit = 16;              // cycles allowed per transfer
    int               cycle_limit;

    `include "tb_fma_model.svh"

    fma_row_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout, the run went past %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // normal operand, exponent field 8..21
    function automatic fma_pkg::fp16_t random_operand();
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] f;
        s = random_bits(1);
        e = random_bits(4);
        f = random_bits(10);
        e = e % 32'd14 + 32'd8;
        return {s[0], e[4:0], f[9:0]};
    endfunction

    // one classic cycle, called and returning on a rising edge
    task automatic bus_xfer(input logic we, input fma_pkg::wb_adr_t adr,
                            input fma_pkg::fp16_t wdata, output fma_pkg::fp16_t rdata);
        int waited;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        waited   = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (wb_ack !== 1'b1 && waited < xfer_limit);
        rdata = wb_dat_r;  // value held through the ack cycle
        if (wb_ack !== 1'b1) begin
            $display("no acknowledge from the DUT for address %0d after %0d cycles", adr, waited);
            fail_count++;
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge clk);
        check_ack("ack lasts one cycle", wb_ack, 1'b0);
    endtask

    task automatic write_operands();
        int i;
        bus_xfer(1'b1, fma_pkg::wb_adr_t'(fma_pkg::ADR_A), cur_a, rd);
        for (i = 0; i < fma_pkg::LANES; i++) begin
            bus_xfer(1'b1, fma_pkg::wb_adr_t'(fma_pkg::ADR_B0 + i), cur_b[i], rd);
            bus_xfer(1'b1, fma_pkg::wb_adr_t'(fma_pkg::ADR_C0 + i), cur_c[i], rd);
        end
    endtask

    task automatic check_lane(input string what, input int lane, input fma_pkg::fp16_t expected);
        fma_pkg::fp16_t got;
        bus_xfer(1'b0, fma_pkg::wb_adr_t'(fma_pkg::ADR_R0 + lane), '0, got);
        check_fp16(what, lane, got, expected);
    endtask

    task automatic check_results(input string what);
        int i;
        for (i = 0; i < fma_pkg::LANES; i++)
            check_lane(what, i, fma_model(cur_a, cur_b[i], cur_c[i]));
    endtask

    task automatic check_operands(input string what);
        int i;
        bus_xfer(1'b0, fma_pkg::wb_adr_t'(fma_pkg::ADR_A), '0, rd);
        check_fp16(what, 0, rd, cur_a);
        for (i = 0; i < fma_pkg::LANES; i++) begin
            bus_xfer(1'b0, fma_pkg::wb_adr_t'(fma_pkg::ADR_B0 + i), '0, rd);
            check_fp16(what, i, rd, cur_b[i]);
            bus_xfer(1'b0, fma_pkg::wb_adr_t'(fma_pkg::ADR_C0 + i), '0, rd);
            check_fp16(what, i, rd, cur_c[i]);
        end
    endtask

    task automatic end_test(input string name);
        if (fail_count == test_start)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d failed checks", name, fail_count - test_start);
        test_start = fail_count;
    endtask

    initial begin
        int i;
        clk      = 1'b0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        cur_a    = '0;
        for (i = 0; i < fma_pkg::LANES; i++) begin
            cur_b[i] = '0;
            cur_c[i] = '0;
        end
        // 13 transfers per round, 46 more in the directed tests
        cycle_limit = 4 * (13 + rounds * 13 + 46) * xfer_limit;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (i = 0; i <= fma_pkg::ADR_R0 + fma_pkg::LANES - 1; i++) begin
            bus_xfer(1'b0, fma_pkg::wb_adr_t'(i), '0, rd);
            check_fp16("reset value", i, rd, '0);
        end
        end_test("reset values");

        repeat (rounds) begin
            cur_a = random_operand();
            for (i = 0; i < fma_pkg::LANES; i++) begin
                cur_b[i] = random_operand();
                cur_c[i] = random_operand();
            end
            write_operands();
            check_results("random operands");
        end
        end_test("random operands");

        cur_a = random_operand();
        bus_xfer(1'b1, fma_pkg::wb_adr_t'(fma_pkg::ADR_A), cur_a, rd);
        check_results("new shared a");
        end_test("new shared a");

        // a * 1.0 - a, then a * 1.0 - (a - ulp)
        cur_a    = 16'h3155;
        cur_b[0] = 16'h3c00;
        cur_c[0] = 16'hb155;
        cur_b[1] = 16'h3c00;
        cur_c[1] = 16'hb154;
        write_operands();
        check_lane("cancellation", 0, 16'h0000);
        check_lane("cancellation", 1, 16'h0800);  // 2^-13
        check_lane("cancellation", 2, fma_model(cur_a, cur_b[2], cur_c[2]));
        check_lane("cancellation", 3, fma_model(cur_a, cur_b[3], cur_c[3]));
        end_test("cancellation");

        cur_a = 16'h3c00;
        cur_b = '{16'h3c00, 16'h3c01, 16'h3fff, 16'h0800};
        cur_c = '{16'h1000, 16'h1000, 16'h1000, 16'h8801};
        write_operands();
        check_lane("tie to even, down", 0, 16'h3c00);
        check_lane("tie to even, up", 1, 16'h3c02);
        check_lane("round carry", 2, 16'h4000);
        check_lane("flush", 3, 16'h8000);  // -2^-23 keeps its sign
        end_test("rounding and flush");

        bus_xfer(1'b0, fma_pkg::wb_adr_t'(13), '0, rd);
        check_fp16("unmapped read", 13, rd, '0);
        bus_xfer(1'b1, fma_pkg::wb_adr_t'(14), 16'hffff, rd);
        check_operands("after unmapped write");
        check_results("after unmapped write");
        end_test("unmapped address");

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
fma_pkg.sv
fma_normalize.sv
fma_lane.sv
fma_row.sv
fma_wb_regs.sv
fma_result_regs.sv
fma_row_top.sv
fma_props.sv
tb_fma_row.sv

// File: Makefile
# Verilator build and run of the fma row testbench

VERILATOR ?= verilator
TOP       ?= tb_fma_row
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
